/* Bender.yml */
package:
  name: csr_subsystem

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/priv_pkg.sv
      - verilog/csr_pkg.sv
      - verilog/csr_alu.sv
      - verilog/trap_ctrl.sv
      - verilog/csr_timer.sv
      - verilog/csr_regfile.sv
      - verilog/csr_top.sv
  - target: test
    files:
      - tests/csr_tb.sv

/* all.f */
+incdir+verilog
verilog/priv_pkg.sv
verilog/csr_pkg.sv
verilog/csr_alu.sv
verilog/trap_ctrl.sv
verilog/csr_timer.sv
verilog/csr_regfile.sv
verilog/csr_top.sv
tests/csr_tb.sv

/* tests/csr_golden.txt */
# win fill op addr src stall exc code exc_pc mret sret ext_m ext_s | rdata ill trap trap_pc mode
# win above 0 repeats the line until trap_taken, at most win cycles; fill adds idle cycles
0 1 0 301 00000000 0 0 00 00000000 0 0 0 0 40140100 0 0 00000000 3
0 0 1 340 12345678 0 0 00 00000000 0 0 0 0 00000000 0 0 00000000 3
0 1 2 340 0000f00f 0 0 00 00000000 0 0 0 0 12345678 0 0 00000000 3
0 0 3 340 12000070 0 0 00 00000000 0 0 0 0 1234f67f 0 0 00000000 3
0 1 0 340 00000000 0 0 00 00000000 0 0 0 0 0034f60f 0 0 00000000 3
0 0 1 305 80000103 0 0 00 00000000 0 0 0 0 00000000 0 0 00000000 3
0 0 2 305 00000040 0 0 00 00000000 0 0 0 0 80000100 0 0 00000000 3
0 1 0 305 00000000 0 0 00 00000000 0 0 0 0 80000140 0 0 00000000 3
0 0 0 341 00000000 0 1 03 00001000 0 0 0 0 00000000 0 1 80000140 3
0 1 0 341 00000000 0 0 00 00000000 0 0 0 0 00001000 0 0 00000000 3
0 0 0 342 00000000 0 0 00 00000000 0 0 0 0 00000003 0 0 00000000 3
0 0 0 300 00000000 0 0 00 00000000 1 0 0 0 00001800 0 0 00001000 3
0 1 0 300 00000000 0 0 00 00000000 0 0 0 0 00000080 0 0 00000000 3
0 0 1 300 00000880 0 0 00 00000000 0 0 0 0 00000080 0 0 00000000 3
0 0 0 300 00000000 0 0 00 00000000 1 0 0 0 00000880 0 0 00001000 3
0 0 2 340 00000000 0 0 00 00002000 0 0 0 0 0034f60f 1 1 80000140 1
0 1 0 342 00000000 0 0 00 00000000 0 0 0 0 00000002 0 0 00000000 3
0 0 0 341 00000000 0 0 00 00000000 0 0 0 0 00002000 0 0 00000000 3
0 0 1 f14 00000005 0 0 00 00003000 0 0 0 0 00000000 1 1 80000140 3
0 1 0 341 00000000 0 0 00 00000000 0 0 0 0 00003000 0 0 00000000 3
0 0 1 302 00000100 0 0 00 00000000 0 0 0 0 00000000 0 0 00000000 3
0 0 1 300 00000000 0 0 00 00000000 0 0 0 0 00001800 0 0 00000000 3
0 0 0 300 00000000 0 0 00 00000000 1 0 0 0 00000000 0 0 00003000 3
0 0 0 141 00000000 0 1 08 00004000 0 0 0 0 00000000 0 1 80000140 0
0 1 2 141 00000000 0 0 00 00000000 0 0 0 0 00004000 0 0 00000000 1
0 0 2 142 00000000 0 0 00 00000000 0 0 0 0 00000008 0 0 00000000 1
0 0 0 300 00000000 0 0 00 00000000 0 1 0 0 00000080 0 0 00004000 1
0 1 0 300 00000000 0 0 00 00000000 0 0 0 0 000000a0 0 0 00000000 0
0 0 0 300 00000000 0 1 03 00005000 0 0 0 0 000000a0 0 1 80000140 0
0 0 0 342 00000000 0 0 00 00000000 0 0 0 0 00000003 0 0 00000000 3
0 0 1 340 deadbeef 1 1 03 00006000 0 0 0 0 0034f60f 0 0 00006000 3
0 1 0 340 00000000 0 0 00 00000000 0 0 0 0 0034f60f 0 0 00000000 3
0 0 0 341 00000000 0 0 00 00000000 0 0 0 0 00005000 0 0 00000000 3
0 0 1 304 00000080 0 0 00 00000000 0 0 0 0 00000000 0 0 00000000 3
0 0 2 300 00000008 0 0 00 00000000 0 0 0 0 00000020 0 0 00000000 3
0 0 1 7c0 00000010 0 0 00 00000000 0 0 0 0 ffffffff 0 0 00000000 3
8 0 0 342 00000000 0 0 00 00000000 0 0 0 0 00000003 0 1 80000140 3
0 1 0 342 00000000 0 0 00 00000000 0 0 0 0 80000007 0 0 00000000 3
0 0 0 300 00000000 0 0 00 00000000 0 0 0 0 000018a0 0 0 00000000 3
0 0 0 7c0 00000000 0 0 00 00000000 0 0 0 0 00000010 0 0 00000000 3

/* tests/csr_tb.sv */
`timescale 1ns/1ns
`include "csr_defs.svh"

module csr_tb
	import priv_pkg::*;
	import csr_pkg::*;
();

	// one scripted cycle, as read from the golden file
	typedef struct packed
	{
		logic [7:0]        win;     // 0 = single cycle, else wait for trap_taken
		logic [7:0]        fill;    // idle cycles after this step
		logic [1:0]        op;
		logic [11:0]       addr;
		logic [`XLEN-1:0]  src;
		logic              stall;
		logic              exc;
		logic [4:0]        code;
		logic [`XLEN-1:0]  pc;
		logic              mret;
		logic              sret;
		logic              ext_m;
		logic              ext_s;
		logic [`XLEN-1:0]  exp_rdata;
		logic              exp_ill;
		logic              exp_trap;
		logic [`XLEN-1:0]  exp_pc;
		logic [1:0]        exp_mode;
	} step_t;

	logic             clk;
	logic             nrst;
	csr_op_t          csr_op;
	logic [11:0]      csr_addr;
	logic [`XLEN-1:0] csr_src;
	logic             stall;
	logic             exc_valid;
	exc_code_t        exc_code;
	logic [`XLEN-1:0] exc_pc;
	logic             m_ret;
	logic             s_ret;
	logic             ext_m_irq;
	logic             ext_s_irq;
	logic [`XLEN-1:0] csr_rdata;
	logic             illegal;
	logic             trap_taken;
	logic [`XLEN-1:0] trap_pc;
	mode_t            current_mode;

	step_t  steps[$];
	integer seed;
	int     mismatches;
	int     other_errors;
	longint budget_ns;

	csr_top i_csr_top (
		.clk          (clk),
		.nrst         (nrst),
		.csr_op       (csr_op),
		.csr_addr     (csr_addr),
		.csr_src      (csr_src),
		.stall        (stall),
		.exc_valid    (exc_valid),
		.exc_code     (exc_code),
		.exc_pc       (exc_pc),
		.m_ret        (m_ret),
		.s_ret        (s_ret),
		.ext_m_irq    (ext_m_irq),
		.ext_s_irq    (ext_s_irq),
		.csr_rdata    (csr_rdata),
		.illegal      (illegal),
		.trap_taken   (trap_taken),
		.trap_pc      (trap_pc),
		.current_mode (current_mode)
	);

	always #20 clk = ~clk;

	task automatic load_golden();
		int          fd;
		int          n;
		string       line;
		logic [31:0] f [18];
		step_t       s;

		fd = $fopen("tests/csr_golden.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the golden file tests/csr_golden.txt");
			other_errors++;
			return;
		end
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line.getc(0) == "#")
				continue;   // blank or comment
			n = $sscanf(line, "%d %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
				f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]);
			if (n != 18)
			begin
				$display("golden file line has %0d fields instead of 18: %s", n, line);
				other_errors++;
				continue;
			end
			s = {f[0][7:0], f[1][7:0], f[2][1:0], f[3][11:0], f[4], f[5][0], f[6][0],
				f[7][4:0], f[8], f[9][0], f[10][0], f[11][0], f[12][0], f[13],
				f[14][0], f[15][0], f[16], f[17][1:0]};
			steps.push_back(s);
		end
		$fclose(fd);
		if (steps.size() == 0)
		begin
			$display("golden file holds no steps");
			other_errors++;
		end
	endtask

	task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
		if (actual !== expected)
		begin
			mismatches++;
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic drive_step(step_t s);
		csr_op    = csr_op_t'(s.op);
		csr_addr  = s.addr;
		csr_src   = s.src;
		stall     = s.stall;
		exc_valid = s.exc;
		exc_code  = exc_code_t'(s.code);
		exc_pc    = s.pc;
		m_ret     = s.mret;
		s_ret     = s.sret;
		ext_m_irq = s.ext_m;
		ext_s_irq = s.ext_s;
	endtask

	// idle cycle, source bits are don't care with no operation
	task automatic drive_filler();
		csr_op    = OP_NONE;
		csr_addr  = 12'h000;
		csr_src   = $random(seed);
		stall     = 1'b0;
		exc_valid = 1'b0;
		exc_code  = EXC_I_MISALIGNED;
		exc_pc    = '0;
		m_ret     = 1'b0;
		s_ret     = 1'b0;
		ext_m_irq = 1'b0;
		ext_s_irq = 1'b0;
	endtask

	task automatic run_step(step_t s, int idx);
		int   limit;
		int   cycles;
		logic seen;

		limit  = (s.win == 0) ? 1 : s.win;
		cycles = 0;
		seen   = 1'b0;
		while (!seen && cycles < limit)
		begin
			@(posedge clk);
			#2 drive_step(s);
			#36;   // just before the next edge
			cycles++;
			seen = (s.win != 0) && trap_taken;
		end
		if (s.win != 0 && !seen)
		begin
			other_errors++;
			$display("step %0d: no trap was taken within %0d cycles", idx, s.win);
		end
		else
		begin
			check_value("csr_rdata", csr_rdata, s.exp_rdata);
			check_value("illegal", illegal, s.exp_ill);
			check_value("trap_taken", trap_taken, s.exp_trap);
			check_value("trap_pc", trap_pc, s.exp_pc);
			check_value("current_mode", current_mode, s.exp_mode);
		end
		repeat (s.fill)
		begin
			@(posedge clk);
			#2 drive_filler();
		end
	endtask

	// watchdog sized from the golden file
	initial
	begin
		wait (budget_ns != 0);
		#(budget_ns);
		$display("timeout: run did not finish within %0d ns", budget_ns);
		$display("Simulation FAILED");
		$finish;
	end

	initial
	begin
		longint cycles;

		clk          = 1'b0;
		nrst         = 1'b0;
		seed         = 32'h1e606219;
		mismatches   = 0;
		other_errors = 0;
		budget_ns    = 0;
		drive_filler();

		load_golden();
		cycles = 5 + 20;   // reset plus margin
		foreach (steps[i])
			cycles += ((steps[i].win == 0) ? 1 : steps[i].win) + steps[i].fill;
		budget_ns = cycles * 40;

		repeat (5) @(posedge clk);
		#2 nrst = 1'b1;

		foreach (steps[i])
			run_step(steps[i], i);

		$display("errors: %0d mismatches, %0d other failures, %0d steps run",
			mismatches, other_errors, steps.size());
		if (mismatches == 0 && other_errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

/* verilog/csr_alu.sv */
`timescale 1ns/1ns
`include "csr_defs.svh"

module csr_alu
	import priv_pkg::*;
	import csr_pkg::*;
(
	input  logic              clk,
	input  logic              nrst,
	input  csr_op_t           csr_op,
	input  logic [11:0]       csr_addr,
	input  logic [`XLEN-1:0]  csr_src,
	input  logic              stall,
	input  mode_t             current_mode,
	input  logic [`XLEN-1:0]  regfile_rdata,
	input  logic [`XLEN-1:0]  timer_rdata,
	output logic [`XLEN-1:0]  csr_rdata,
	output logic              csr_we,
	output logic [11:0]       csr_waddr,
	output logic [`XLEN-1:0]  csr_wdata,
	output logic              illegal
);

	logic timer_sel;
	logic writes;
	logic priv_bad;
	logic ro_bad;

	// compare registers live in the custom 0xCx window
	assign timer_sel = (csr_addr[7:4] == 4'hC);
	assign csr_rdata = timer_sel ? timer_rdata : regfile_rdata;

	always_comb
	begin
		case (csr_op)
			OP_WRITE: csr_wdata = csr_src;
			OP_SET:   csr_wdata = csr_rdata | csr_src;
			OP_CLEAR: csr_wdata = csr_rdata & ~csr_src;
			default:  csr_wdata = csr_rdata;
		endcase
	end

	// set or clear with zero source is a pure read
	assign writes = (csr_op == OP_WRITE) ||
		((csr_op == OP_SET || csr_op == OP_CLEAR) && csr_src != '0);

	assign priv_bad = (csr_op != OP_NONE) && (csr_addr[9:8] > current_mode);
	assign ro_bad   = writes && (csr_addr[11:10] == 2'b11);
	assign illegal  = priv_bad || ro_bad;

	assign csr_we    = writes && !illegal && !stall;
	assign csr_waddr = csr_addr;

	// the privilege compare only knows U, S and M
	legal_mode: assert property (@(posedge clk) disable iff (!nrst)
		current_mode != 2'b10);

endmodule

/* verilog/csr_defs.svh */
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// data width of the hart
`define XLEN 32

// machine information, read only
`define CSR_MVENDORID 12'hF11
`define CSR_MARCHID   12'hF12
`define CSR_MIMPID    12'hF13
`define CSR_MHARTID   12'hF14

// machine trap setup
`define CSR_MSTATUS   12'h300
`define CSR_MISA      12'h301
`define CSR_MEDELEG   12'h302
`define CSR_MIDELEG   12'h303
`define CSR_MIE       12'h304
`define CSR_MTVEC     12'h305

// machine trap handling
`define CSR_MSCRATCH  12'h340
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342
`define CSR_MTVAL     12'h343
`define CSR_MIP       12'h344

// supervisor trap handling
`define CSR_SEPC      12'h141
`define CSR_SCAUSE    12'h142
`define CSR_STVAL     12'h143

// timer compare, custom read/write space
`define CSR_MTIMECMP  12'h7C0
`define CSR_STIMECMP  12'h5C0

`endif

/* verilog/csr_pkg.sv */
`include "csr_defs.svh"

package csr_pkg;

	typedef enum logic [1:0]
	{
		OP_NONE  = 2'b00,
		OP_WRITE = 2'b01,
		OP_SET   = 2'b10,
		OP_CLEAR = 2'b11
	} csr_op_t;

	// mstatus layout, msb first
	typedef struct packed
	{
		logic [`XLEN-20:0] zero_hi;
		logic              sum;   // bit 18
		logic [4:0]        zero_17_13;
		logic [1:0]        mpp;   // bits 12:11
		logic [1:0]        zero_10_9;
		logic              spp;
		logic              mpie;
		logic              zero_6;
		logic              spie;
		logic              zero_4;
		logic              mie;
		logic              zero_2;
		logic              sie;
		logic              zero_0;
	} status_bits_t;

	// shared by mie and mip
	typedef struct packed
	{
		logic [19:0] zero_hi;
		logic        meie;    // bit 11
		logic        zero_10;
		logic        seie;
		logic        zero_8;
		logic        mtie;
		logic        zero_6;
		logic        stie;
		logic        zero_4;
		logic        msie;
		logic        zero_2;
		logic        ssie;
		logic        zero_0;
	} ie_bits_t;

	// one write word, decoded by address
	typedef union packed
	{
		status_bits_t status;
		ie_bits_t     ie;
	} csr_word_u;

endpackage

/* verilog/csr_regfile.sv */
`timescale 1ns/1ns
`include "csr_defs.svh"

module csr_regfile
	import priv_pkg::*;
	import csr_pkg::*;
(
	input  logic              clk,
	input  logic              nrst,
	input  logic              csr_we,
	input  logic [11:0]       csr_waddr,
	input  logic [`XLEN-1:0]  csr_wdata,
	input  logic [11:0]       csr_addr,
	input  logic              stall,
	input  logic              m_ret,
	input  logic              s_ret,
	input  logic              ext_m_irq,
	input  logic              ext_s_irq,
	input  logic              m_timer,
	input  logic              s_timer,
	input  logic              trap_take,
	input  logic              trap_to_s,
	input  logic              trap_irq,
	input  logic [4:0]        trap_code,
	input  logic [`XLEN-1:0]  trap_pc,
	output logic [`XLEN-1:0]  regfile_rdata,
	output mode_t             current_mode,
	output logic [`XLEN-1:0]  medeleg,
	output logic [`XLEN-1:0]  mideleg,
	output logic [`XLEN-1:0]  irq_pend,
	output logic              sie,
	output logic              mie,
	output logic [`XLEN-1:0]  epc
);

	// rv32 with I, S and U
	localparam logic [`XLEN-1:0] MISA_VAL = 32'h4014_0100;

	status_bits_t     status_q;
	ie_bits_t         ie_q;
	ie_bits_t         ip;
	csr_word_u        wword;
	logic [`XLEN-1:0] mtvec;
	logic [`XLEN-1:0] mepc;
	logic [`XLEN-1:0] mcause;
	logic [`XLEN-1:0] mtval;
	logic [`XLEN-1:0] mscratch;
	logic [`XLEN-1:0] sepc;
	logic [`XLEN-1:0] scause;
	logic [`XLEN-1:0] stval;
	logic [`XLEN-1:0] cause_val;
	logic [`XLEN-1:0] tval_val;

	assign wword = csr_wdata;

	// pending bits come straight from the sources
	always_comb
	begin
		ip      = '0;
		ip.meie = ext_m_irq;
		ip.seie = ext_s_irq;
		ip.mtie = m_timer;
		ip.stie = s_timer;
	end

	assign irq_pend = ip & ie_q;
	assign sie      = status_q.sie;
	assign mie      = status_q.mie;

	assign cause_val = {trap_irq, {(`XLEN-6){1'b0}}, trap_code};
	// only a misaligned fetch reports its address
	assign tval_val  = (!trap_irq && trap_code == EXC_I_MISALIGNED) ? trap_pc : '0;

	always_comb
	begin
		case (csr_addr)
			`CSR_MISA:      regfile_rdata = MISA_VAL;
			`CSR_MVENDORID: regfile_rdata = '0;
			`CSR_MARCHID:   regfile_rdata = '0;
			`CSR_MIMPID:    regfile_rdata = '0;
			`CSR_MHARTID:   regfile_rdata = '0;
			`CSR_MSTATUS:   regfile_rdata = status_q;
			`CSR_MIE:       regfile_rdata = ie_q;
			`CSR_MIP:       regfile_rdata = ip;
			`CSR_MTVEC:     regfile_rdata = mtvec;
			`CSR_MEPC:      regfile_rdata = mepc;
			`CSR_MCAUSE:    regfile_rdata = mcause;
			`CSR_MTVAL:     regfile_rdata = mtval;
			`CSR_MSCRATCH:  regfile_rdata = mscratch;
			`CSR_MEDELEG:   regfile_rdata = medeleg;
			`CSR_MIDELEG:   regfile_rdata = mideleg;
			`CSR_SEPC:      regfile_rdata = sepc;
			`CSR_SCAUSE:    regfile_rdata = scause;
			`CSR_STVAL:     regfile_rdata = stval;
			default:        regfile_rdata = '0;
		endcase
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			current_mode <= MODE_M;
			status_q     <= '0;
			ie_q         <= '0;
			mtvec        <= '0;
			mepc         <= '0;
			mcause       <= '0;
			mtval        <= '0;
			mscratch     <= '0;
			medeleg      <= '0;
			mideleg      <= '0;
			sepc         <= '0;
			scause       <= '0;
			stval        <= '0;
		end
		else if (trap_take)
		begin
			if (trap_to_s)
			begin
				sepc          <= trap_pc;
				scause        <= cause_val;
				stval         <= tval_val;
				status_q.spie <= status_q.sie;
				status_q.sie  <= 1'b0;
				status_q.spp  <= (current_mode == MODE_S);
				current_mode  <= MODE_S;
			end
			else
			begin
				mepc          <= trap_pc;
				mcause        <= cause_val;
				mtval         <= tval_val;
				status_q.mpie <= status_q.mie;
				status_q.mie  <= 1'b0;
				status_q.mpp  <= current_mode;
				current_mode  <= MODE_M;
			end
		end
		else if (m_ret && !stall)
		begin
			status_q.mie  <= status_q.mpie;
			status_q.mpie <= 1'b1;
			status_q.mpp  <= MODE_U;
			current_mode  <= mode_t'(status_q.mpp);
		end
		else if (s_ret && !stall)
		begin
			status_q.sie  <= status_q.spie;
			status_q.spie <= 1'b1;
			status_q.spp  <= 1'b0;
			current_mode  <= status_q.spp ? MODE_S : MODE_U;
		end
		else if (csr_we)
		begin
			case (csr_waddr)
				`CSR_MSTATUS:
				begin
					status_q.sie  <= wword.status.sie;
					status_q.mie  <= wword.status.mie;
					status_q.spie <= wword.status.spie;
					status_q.mpie <= wword.status.mpie;
					status_q.spp  <= wword.status.spp;
					status_q.mpp  <= wword.status.mpp;
					status_q.sum  <= wword.status.sum;
				end
				`CSR_MIE:
				begin
					ie_q.ssie <= wword.ie.ssie;
					ie_q.msie <= wword.ie.msie;
					ie_q.stie <= wword.ie.stie;
					ie_q.mtie <= wword.ie.mtie;
					ie_q.seie <= wword.ie.seie;
					ie_q.meie <= wword.ie.meie;
				end
				`CSR_MTVEC:    mtvec    <= {csr_wdata[`XLEN-1:2], 2'b00};  // direct mode only
				`CSR_MEPC:     mepc     <= {csr_wdata[`XLEN-1:2], 2'b00};
				`CSR_MCAUSE:   mcause   <= csr_wdata;
				`CSR_MTVAL:    mtval    <= csr_wdata;
				`CSR_MSCRATCH: mscratch <= csr_wdata;
				`CSR_MEDELEG:  medeleg  <= csr_wdata;
				`CSR_MIDELEG:  mideleg  <= csr_wdata;
				`CSR_SEPC:     sepc     <= {csr_wdata[`XLEN-1:2], 2'b00};
				`CSR_SCAUSE:   scause   <= csr_wdata;
				`CSR_STVAL:    stval    <= csr_wdata;
				default:       ;
			endcase
		end
	end

	// redirect target for the front end
	always_comb
	begin
		if (m_ret)
			epc = mepc;
		else if (s_ret)
			epc = sepc;
		else
			epc = mtvec;
	end

	// the two returns come from one decoded instruction
	one_return: assert property (@(posedge clk) disable iff (!nrst)
		!(m_ret && s_ret));

	// trap entry above is not qualified by stall
	stall_blocks_trap: assert property (@(posedge clk) disable iff (!nrst)
		stall |-> !trap_take);

endmodule

/* verilog/csr_timer.sv */
`timescale 1ns/1ns
`include "csr_defs.svh"

module csr_timer
(
	input  logic              clk,
	input  logic              nrst,
	input  logic              csr_we,
	input  logic [11:0]       csr_waddr,
	input  logic [`XLEN-1:0]  csr_wdata,
	input  logic [11:0]       csr_addr,
	output logic [`XLEN-1:0]  timer_rdata,
	output logic              m_timer,
	output logic              s_timer
);

	logic [`XLEN-1:0] cycle_cnt;
	logic [`XLEN-1:0] mtimecmp;
	logic [`XLEN-1:0] stimecmp;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			cycle_cnt <= '0;
			mtimecmp  <= '1;   // no timer event until programmed
			stimecmp  <= '1;
			m_timer   <= 1'b0;
			s_timer   <= 1'b0;
		end
		else
		begin
			cycle_cnt <= cycle_cnt + 1'b1;
			m_timer   <= (cycle_cnt >= mtimecmp);
			s_timer   <= (cycle_cnt >= stimecmp);
			if (csr_we && csr_waddr == `CSR_MTIMECMP)
				mtimecmp <= csr_wdata;
			if (csr_we && csr_waddr == `CSR_STIMECMP)
				stimecmp <= csr_wdata;
		end
	end

	always_comb
	begin
		case (csr_addr)
			`CSR_MTIMECMP: timer_rdata = mtimecmp;
			`CSR_STIMECMP: timer_rdata = stimecmp;
			default:       timer_rdata = '0;
		endcase
	end

endmodule

/* verilog/csr_top.sv */
`timescale 1ns/1ns
`include "csr_defs.svh"

module csr_top
	import priv_pkg::*;
	import csr_pkg::*;
(
	input  logic              clk,
	input  logic              nrst,
	input  csr_op_t           csr_op,
	input  logic [11:0]       csr_addr,
	input  logic [`XLEN-1:0]  csr_src,
	input  logic              stall,
	input  logic              exc_valid,
	input  exc_code_t         exc_code,
	input  logic [`XLEN-1:0]  exc_pc,
	input  logic              m_ret,
	input  logic              s_ret,
	input  logic              ext_m_irq,
	input  logic              ext_s_irq,
	output logic [`XLEN-1:0]  csr_rdata,
	output logic              illegal,
	output logic              trap_taken,
	output logic [`XLEN-1:0]  trap_pc,
	output mode_t             current_mode
);

	logic             csr_we;
	logic [11:0]      csr_waddr;
	logic [`XLEN-1:0] csr_wdata;
	logic [`XLEN-1:0] regfile_rdata;
	logic [`XLEN-1:0] timer_rdata;
	logic             m_timer;
	logic             s_timer;
	logic [`XLEN-1:0] medeleg;
	logic [`XLEN-1:0] mideleg;
	logic [`XLEN-1:0] irq_pend;
	logic             sie;
	logic             mie;
	logic [`XLEN-1:0] epc;
	logic             trap_to_s;
	logic             trap_irq;
	logic [4:0]       trap_code;
	logic [`XLEN-1:0] saved_pc;   // pc of the trapping instruction

	csr_alu i_csr_alu (
		.clk           (clk),
		.nrst          (nrst),
		.csr_op        (csr_op),
		.csr_addr      (csr_addr),
		.csr_src       (csr_src),
		.stall         (stall),
		.current_mode  (current_mode),
		.regfile_rdata (regfile_rdata),
		.timer_rdata   (timer_rdata),
		.csr_rdata     (csr_rdata),
		.csr_we        (csr_we),
		.csr_waddr     (csr_waddr),
		.csr_wdata     (csr_wdata),
		.illegal       (illegal)
	);

	trap_ctrl i_trap_ctrl (
		.exc_valid    (exc_valid),
		.exc_code     (exc_code),
		.exc_pc       (exc_pc),
		.illegal      (illegal),
		.stall        (stall),
		.current_mode (current_mode),
		.medeleg      (medeleg),
		.mideleg      (mideleg),
		.irq_pend     (irq_pend),
		.sie          (sie),
		.mie          (mie),
		.trap_take    (trap_taken),
		.trap_to_s    (trap_to_s),
		.trap_irq     (trap_irq),
		.trap_code    (trap_code),
		.trap_pc      (saved_pc)
	);

	csr_timer i_csr_timer (
		.clk         (clk),
		.nrst        (nrst),
		.csr_we      (csr_we),
		.csr_waddr   (csr_waddr),
		.csr_wdata   (csr_wdata),
		.csr_addr    (csr_addr),
		.timer_rdata (timer_rdata),
		.m_timer     (m_timer),
		.s_timer     (s_timer)
	);

	csr_regfile i_csr_regfile (
		.clk           (clk),
		.nrst          (nrst),
		.csr_we        (csr_we),
		.csr_waddr     (csr_waddr),
		.csr_wdata     (csr_wdata),
		.csr_addr      (csr_addr),
		.stall         (stall),
		.m_ret         (m_ret),
		.s_ret         (s_ret),
		.ext_m_irq     (ext_m_irq),
		.ext_s_irq     (ext_s_irq),
		.m_timer       (m_timer),
		.s_timer       (s_timer),
		.trap_take     (trap_taken),
		.trap_to_s     (trap_to_s),
		.trap_irq      (trap_irq),
		.trap_code     (trap_code),
		.trap_pc       (saved_pc),
		.regfile_rdata (regfile_rdata),
		.current_mode  (current_mode),
		.medeleg       (medeleg),
		.mideleg       (mideleg),
		.irq_pend      (irq_pend),
		.sie           (sie),
		.mie           (mie),
		.epc           (epc)
	);

	// redirect on trap or return, else pass the faulting pc
	assign trap_pc = (trap_taken || m_ret || s_ret) ? epc : saved_pc;

endmodule

/* verilog/priv_pkg.sv */
package priv_pkg;

	// privilege level, encoded as in csr address bits 9:8
	typedef enum logic [1:0]
	{
		MODE_U = 2'b00,
		MODE_S = 2'b01,
		MODE_M = 2'b11
	} mode_t;

	// synchronous exception causes
	typedef enum logic [4:0]
	{
		EXC_I_MISALIGNED = 5'd0,
		EXC_ILLEGAL      = 5'd2,
		EXC_BREAKPOINT   = 5'd3,
		EXC_ECALL_U      = 5'd8,
		EXC_ECALL_S      = 5'd9,
		EXC_ECALL_M      = 5'd11
	} exc_code_t;

	// interrupt causes, also the bit index in mip and mie
	typedef enum logic [4:0]
	{
		IRQ_S_TIMER = 5'd5,
		IRQ_M_TIMER = 5'd7,
		IRQ_S_EXT   = 5'd9,
		IRQ_M_EXT   = 5'd11
	} irq_code_t;

endpackage

/* verilog/trap_ctrl.sv */
`timescale 1ns/1ns
`include "csr_defs.svh"

module trap_ctrl
	import priv_pkg::*;
(
	input  logic              exc_valid,
	input  exc_code_t         exc_code,
	input  logic [`XLEN-1:0]  exc_pc,
	input  logic              illegal,
	input  logic              stall,
	input  mode_t             current_mode,
	input  logic [`XLEN-1:0]  medeleg,
	input  logic [`XLEN-1:0]  mideleg,
	input  logic [`XLEN-1:0]  irq_pend,
	input  logic              sie,
	input  logic              mie,
	output logic              trap_take,
	output logic              trap_to_s,
	output logic              trap_irq,
	output logic [4:0]        trap_code,
	output logic [`XLEN-1:0]  trap_pc
);

	// lowest priority first, later hits override
	localparam irq_code_t IRQ_ORDER [4] = '{IRQ_S_TIMER, IRQ_S_EXT, IRQ_M_TIMER, IRQ_M_EXT};

	logic      sync_hit;
	exc_code_t sync_code;
	logic      sync_to_s;
	logic      irq_hit;
	irq_code_t irq_sel;
	logic      irq_to_s;

	// illegal csr access becomes an illegal instruction
	assign sync_hit  = exc_valid || illegal;
	assign sync_code = exc_valid ? exc_code : EXC_ILLEGAL;
	assign sync_to_s = medeleg[sync_code] && (current_mode != MODE_M);

	always_comb
	begin : irq_arb
		mode_t tgt;
		logic  allowed;

		irq_hit  = 1'b0;
		irq_sel  = IRQ_S_TIMER;
		irq_to_s = 1'b0;
		for (int i = 0; i < 4; i++)
		begin
			tgt = (mideleg[IRQ_ORDER[i]] && current_mode != MODE_M) ? MODE_S : MODE_M;
			allowed = (tgt > current_mode) ||
				(tgt == current_mode && ((tgt == MODE_M) ? mie : sie));
			if (irq_pend[IRQ_ORDER[i]] && allowed)
			begin
				irq_hit  = 1'b1;
				irq_sel  = IRQ_ORDER[i];
				irq_to_s = (tgt == MODE_S);
			end
		end
	end

	// exceptions win over interrupts
	assign trap_take = (sync_hit || irq_hit) && !stall;
	assign trap_irq  = !sync_hit && irq_hit;
	assign trap_code = sync_hit ? 5'(sync_code) : 5'(irq_sel);
	assign trap_to_s = sync_hit ? sync_to_s : irq_to_s;
	assign trap_pc   = exc_pc;

endmodule
